// File: hdl/lut_config.svh
`ifndef LUT_CONFIG_SVH
`define LUT_CONFIG_SVH

// Word address inside one table bank
`define LUT_ADDR_W 10

// Bus data word, also the table memory word
`define LUT_WORD_W 32

// One table entry, two of them packed per word
`define LUT_LANE_W 16

// Datapath index input and entry output
`define LUT_DATA_W 32

// External bus address
`define LUT_BUS_ADDR_W 32

// Burst length field
`define LUT_LEN_W 8

`endif

// File: hdl/lut_pkg.sv
`default_nettype none

`include "lut_config.svh"

package lut_pkg;

   // Run configuration, held stable while a load is busy
   typedef struct packed {
      logic [`LUT_BUS_ADDR_W-1:0] ext_addr;
      logic [`LUT_ADDR_W-1:0]     iterations;
      logic [`LUT_ADDR_W-1:0]     period;
      logic [`LUT_ADDR_W-1:0]     duty;
      logic [`LUT_ADDR_W-1:0]     shift;
      logic [`LUT_ADDR_W-1:0]     incr;
      logic [`LUT_LEN_W-1:0]      length;
      logic                       ping_pong;
   } lut_cfg_t;

   typedef struct packed {
      logic                       valid;
      logic [`LUT_BUS_ADDR_W-1:0] addr;
      logic [`LUT_LEN_W-1:0]      len;
   } lut_bus_req_t;

   typedef struct packed {
      logic                   ready;
      logic [`LUT_WORD_W-1:0] rdata;
      logic                   last;
   } lut_bus_rsp_t;

   // Table write, bank bit on top of the word address
   typedef struct packed {
      logic                   en;
      logic [`LUT_ADDR_W:0]   addr;
      logic [`LUT_WORD_W-1:0] data;
   } lut_wr_t;

   typedef enum logic [1:0] {AG_IDLE, AG_EMIT, AG_SHIFT} ag_state_e;

   typedef enum logic {LOAD_IDLE, LOAD_BUSY} load_state_e;

endpackage

`default_nettype wire

// File: hdl/lut_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "lut_config.svh"

module lut_addr_gen (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   run_i,
   input  lut_pkg::lut_cfg_t      cfg_i,
   input  logic                   ready_i,
   output logic                   valid_o,
   output logic [`LUT_ADDR_W-1:0] addr_o,
   output logic                   done_o
);

   import lut_pkg::*;

   ag_state_e            state_q;
   logic [`LUT_ADDR_W-1:0] iter_q;
   logic [`LUT_ADDR_W-1:0] pos_q;
   logic [`LUT_ADDR_W:0]   pos_next;
   logic [`LUT_ADDR_W:0]   iter_next;
   logic                   last_pos;
   logic                   last_iter;
   logic                   empty_run;

   // One extra bit so the compare does not wrap at the top of the range
   assign pos_next  = {1'b0, pos_q} + 1'b1;
   assign iter_next = {1'b0, iter_q} + 1'b1;

   // Positions at or past duty take no cycles, the bus never sees a hole
   assign last_pos  = (pos_next >= {1'b0, cfg_i.duty}) ||
                      (pos_next >= {1'b0, cfg_i.period});
   assign last_iter = (iter_next >= {1'b0, cfg_i.iterations});
   assign empty_run = (cfg_i.iterations == '0) || (cfg_i.period == '0);

   assign valid_o = (state_q == AG_EMIT);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q <= AG_IDLE;
         iter_q  <= '0;
         pos_q   <= '0;
         addr_o  <= '0;
         done_o  <= 1'b1;
      end else if (run_i) begin
         iter_q <= '0;
         pos_q  <= '0;
         addr_o <= '0;
         if (empty_run) begin
            state_q <= AG_IDLE;
            done_o  <= 1'b1;
         end else begin
            // Zero duty means whole periods of nothing but shift
            state_q <= (cfg_i.duty == '0) ? AG_SHIFT : AG_EMIT;
            done_o  <= 1'b0;
         end
      end else begin
         case (state_q)
            AG_EMIT: begin
               if (ready_i) begin
                  if (!last_pos) begin
                     pos_q  <= pos_next[`LUT_ADDR_W-1:0];
                     addr_o <= addr_o + cfg_i.incr;
                  end else begin
                     // End of the emitting part, apply the period shift too
                     pos_q  <= '0;
                     addr_o <= addr_o + cfg_i.incr + cfg_i.shift;
                     if (last_iter) begin
                        state_q <= AG_IDLE;
                        done_o  <= 1'b1;
                     end else begin
                        iter_q <= iter_next[`LUT_ADDR_W-1:0];
                     end
                  end
               end
            end
            AG_SHIFT: begin
               addr_o <= addr_o + cfg_i.shift;
               if (last_iter) begin
                  state_q <= AG_IDLE;
                  done_o  <= 1'b1;
               end else begin
                  iter_q <= iter_next[`LUT_ADDR_W-1:0];
               end
            end
            default: begin
               state_q <= AG_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/lut_mem_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "lut_config.svh"

module lut_mem_writer (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   gen_valid_i,
   input  logic [`LUT_ADDR_W-1:0] gen_addr_i,
   input  logic                   bank_i,
   input  logic                   beat_i,
   input  logic [`LUT_WORD_W-1:0] rdata_i,
   output logic                   gen_ready_o,
   output lut_pkg::lut_wr_t       wr_o
);

   logic                   en_q;
   logic [`LUT_ADDR_W:0]   addr_q;
   logic [`LUT_WORD_W-1:0] data_q;

   // Every transferred beat consumes one generated address
   assign gen_ready_o = beat_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         en_q <= 1'b0;
      end else begin
         en_q <= beat_i && gen_valid_i;
      end
   end

   // Address and data captured with the beat, written next cycle
   always_ff @(posedge clk) begin
      if (beat_i) begin
         addr_q <= {bank_i, gen_addr_i};
         data_q <= rdata_i;
      end
   end

   assign wr_o = '{en: en_q, addr: addr_q, data: data_q};

endmodule

`default_nettype wire

// File: hdl/lut_table_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "lut_config.svh"

module lut_table_ram (
   input  logic                   clk,
   input  lut_pkg::lut_wr_t       wr_i,
   input  logic [`LUT_ADDR_W:0]   rd_addr_i,
   output logic [`LUT_WORD_W-1:0] rd_data_o
);

   // Two banks of 2^LUT_ADDR_W words each
   localparam int DEPTH = 2 * (1 << `LUT_ADDR_W);

   logic [`LUT_WORD_W-1:0] mem [DEPTH];

   always_ff @(posedge clk) begin
      if (wr_i.en) begin
         mem[wr_i.addr] <= wr_i.data;
      end
   end

   // Registered read, old data on a same-address collision
   always_ff @(posedge clk) begin
      rd_data_o <= mem[rd_addr_i];
   end

endmodule

`default_nettype wire

// File: hdl/lut_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "lut_config.svh"

module lut_reader (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   run_i,
   input  logic                   disabled_i,
   input  lut_pkg::lut_cfg_t      cfg_i,
   input  logic [`LUT_DATA_W-1:0] index_i,
   input  lut_pkg::lut_bus_rsp_t  bus_rsp_i,
   input  logic                   gen_ready_i,
   output lut_pkg::lut_bus_req_t  bus_req_o,
   output logic                   beat_o,
   output logic [`LUT_ADDR_W:0]   rd_addr_o,
   input  logic [`LUT_WORD_W-1:0] rd_data_i,
   output logic [`LUT_DATA_W-1:0] data_o,
   output logic                   bank_o,
   output logic                   gen_run_o,
   output logic                   done_o
);

   import lut_pkg::*;

   load_state_e                load_q;
   logic                       bank_q;
   logic [`LUT_BUS_ADDR_W-1:0] bus_addr_q;
   logic                       bus_valid;
   logic                       enabled_run;
   logic                       last_beat;
   logic                       rd_bank;
   logic                       lane_q;
   logic                       lane_qq;
   logic [`LUT_LANE_W-1:0]     entry;

   assign enabled_run = run_i && !disabled_i;
   assign gen_run_o   = enabled_run;

   assign bus_valid = (load_q == LOAD_BUSY);
   assign bus_req_o = '{valid: bus_valid, addr: bus_addr_q, len: cfg_i.length};
   assign beat_o    = bus_valid && bus_rsp_i.ready;

   // The writer acknowledges exactly the transferred beats
   assign last_beat = gen_ready_i && bus_rsp_i.last;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         load_q <= LOAD_IDLE;
         done_o <= 1'b1;
      end else if (enabled_run) begin
         load_q <= LOAD_BUSY;
         done_o <= 1'b0;
      end else if (last_beat) begin
         load_q <= LOAD_IDLE;
         done_o <= 1'b1;
      end
   end

   // Bank flips on every run, also a disabled one
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bank_q <= 1'b0;
      end else if (run_i) begin
         bank_q <= cfg_i.ping_pong ? !bank_q : 1'b0;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bus_addr_q <= '0;
      end else if (enabled_run) begin
         bus_addr_q <= cfg_i.ext_addr;
      end
   end

   assign bank_o = bank_q;

   // Reads come from the bank not being loaded
   assign rd_bank = cfg_i.ping_pong ? !bank_q : 1'b0;

   // Lane bit follows the address one stage behind, lined up with RAM data
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_addr_o <= '0;
         lane_q    <= 1'b0;
         lane_qq   <= 1'b0;
      end else begin
         rd_addr_o <= {rd_bank, index_i[`LUT_ADDR_W:1]};
         lane_q    <= index_i[0];
         lane_qq   <= lane_q;
      end
   end

   assign entry  = lane_qq ? rd_data_i[2*`LUT_LANE_W-1:`LUT_LANE_W]
                           : rd_data_i[`LUT_LANE_W-1:0];
   assign data_o = {{(`LUT_DATA_W-`LUT_LANE_W){1'b0}}, entry};

endmodule

`default_nettype wire

// File: hdl/lut_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lut_config.svh"

module lut_top (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   run_i,
   input  logic                   disabled_i,
   input  lut_pkg::lut_cfg_t      cfg_i,
   input  logic [`LUT_DATA_W-1:0] index_i,
   input  lut_pkg::lut_bus_rsp_t  bus_rsp_i,
   output lut_pkg::lut_bus_req_t  bus_req_o,
   output logic [`LUT_DATA_W-1:0] data_o,
   output logic                   done_o
);

   import lut_pkg::*;

   logic                   gen_run;
   logic                   gen_valid;
   logic                   gen_ready;
   logic [`LUT_ADDR_W-1:0] gen_addr;
   logic                   bank;
   logic                   beat;
   lut_wr_t                wr;
   logic [`LUT_ADDR_W:0]   rd_addr;
   logic [`LUT_WORD_W-1:0] rd_data;

   lut_reader u_reader (
      .clk        (clk),
      .rst        (rst),
      .run_i      (run_i),
      .disabled_i (disabled_i),
      .cfg_i      (cfg_i),
      .index_i    (index_i),
      .bus_rsp_i  (bus_rsp_i),
      .gen_ready_i(gen_ready),
      .bus_req_o  (bus_req_o),
      .beat_o     (beat),
      .rd_addr_o  (rd_addr),
      .rd_data_i  (rd_data),
      .data_o     (data_o),
      .bank_o     (bank),
      .gen_run_o  (gen_run),
      .done_o     (done_o)
   );

   // Load completion is tracked by the reader from the bus last flag
   lut_addr_gen u_addr_gen (
      .clk    (clk),
      .rst    (rst),
      .run_i  (gen_run),
      .cfg_i  (cfg_i),
      .ready_i(gen_ready),
      .valid_o(gen_valid),
      .addr_o (gen_addr),
      .done_o ()
   );

   lut_mem_writer u_writer (
      .clk        (clk),
      .rst        (rst),
      .gen_valid_i(gen_valid),
      .gen_addr_i (gen_addr),
      .bank_i     (bank),
      .beat_i     (beat),
      .rdata_i    (bus_rsp_i.rdata),
      .gen_ready_o(gen_ready),
      .wr_o       (wr)
   );

   lut_table_ram u_ram (
      .clk      (clk),
      .wr_i     (wr),
      .rd_addr_i(rd_addr),
      .rd_data_o(rd_data)
   );

endmodule

`default_nettype wire

// File: testbench/lut_tb_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module lut_tb_assertions (
   input logic                  clk,
   input logic                  rst,
   input lut_pkg::lut_bus_req_t bus_req_i,
   input lut_pkg::lut_bus_rsp_t bus_rsp_i,
   input logic                  done_i,
   input logic                  beat_i,
   input logic                  wr_en_i
);

   int valid_fails = 0;
   int overlap_fails = 0;
   int write_fails = 0;

   // A burst request is held until its last beat transfers
   valid_held: assert property (@(posedge clk) disable iff (rst)
      bus_req_i.valid && !(bus_rsp_i.ready && bus_rsp_i.last) |=> bus_req_i.valid)
      else begin
         valid_fails++;
         $error("bus valid dropped before the last beat");
      end

   done_idle: assert property (@(posedge clk) disable iff (rst)
      !(done_i && bus_req_i.valid))
      else begin
         overlap_fails++;
         $error("done and bus valid high in the same cycle");
      end

   // Writer registers the beat, so the write trails it by one cycle
   write_after_beat: assert property (@(posedge clk) disable iff (rst)
      wr_en_i |-> $past(beat_i))
      else begin
         write_fails++;
         $error("table write without a beat in the previous cycle");
      end

endmodule

bind lut_top lut_tb_assertions u_checks (
   .clk      (clk),
   .rst      (rst),
   .bus_req_i(bus_req_o),
   .bus_rsp_i(bus_rsp_i),
   .done_i   (done_o),
   .beat_i   (beat),
   .wr_en_i  (wr.en)
);

`default_nettype wire

// File: testbench/lut_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lut_config.svh"

module lut_tb;

   import lut_pkg::*;

   localparam int WORDS = 2 * (1 << `LUT_ADDR_W);

   logic                   clk;
   logic                   rst;
   logic                   run_i;
   logic                   disabled_i;
   lut_cfg_t               cfg_i;
   logic [`LUT_DATA_W-1:0] index_i;
   lut_bus_rsp_t           bus_rsp_i;
   lut_bus_req_t           bus_req_o;
   logic [`LUT_DATA_W-1:0] data_o;
   logic                   done_o;

   logic [15:0]            lfsr;
   logic [`LUT_WORD_W-1:0] shadow [WORDS];
   logic [`LUT_ADDR_W-1:0] addr_q [$];
   int                     idx_list [$];
   logic                   load_bank;
   logic                   backpressure;
   logic                   aborted;
   int                     errors;
   int                     checks;

   lut_top lut_top_i (
      .clk       (clk),
      .rst       (rst),
      .run_i     (run_i),
      .disabled_i(disabled_i),
      .cfg_i     (cfg_i),
      .index_i   (index_i),
      .bus_rsp_i (bus_rsp_i),
      .bus_req_o (bus_req_o),
      .data_o    (data_o),
      .done_o    (done_o)
   );

   always #20 clk = ~clk;

   // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic lfsr_bit();
      logic out;
      out = lfsr[0];
      lfsr = lfsr >> 1;
      if (out) begin
         lfsr = lfsr ^ 16'hB400;
      end
      return out;
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_bit()};
      end
      return v;
   endfunction

   // Bus slave: one LFSR word per beat, each beat lands in the shadow table
   initial begin : bus_model
      logic word_pending;
      logic beat_armed;
      logic [`LUT_ADDR_W-1:0] a;
      lfsr = 16'd42863;
      bus_rsp_i = '0;
      word_pending = 1'b0;
      beat_armed = 1'b0;
      forever begin
         @(negedge clk);
         if (beat_armed && bus_rsp_i.ready && addr_q.size() > 0) begin
            a = addr_q.pop_front();
            shadow[{load_bank, a}] = bus_rsp_i.rdata;
            word_pending = 1'b0;
         end
         beat_armed = bus_req_o.valid && !rst;
         if (beat_armed && addr_q.size() > 0) begin
            if (!word_pending) begin
               bus_rsp_i.rdata = random_bits(`LUT_WORD_W);
               word_pending = 1'b1;
            end
            bus_rsp_i.ready = backpressure ? lfsr_bit() : 1'b1;
            bus_rsp_i.last = (addr_q.size() == 1);
         end else begin
            bus_rsp_i.ready = 1'b0;
            bus_rsp_i.last = 1'b0;
         end
      end
   end

   // Word order of a load, straight from the iteration/period/duty rule
   task automatic queue_load_addresses(input lut_cfg_t cfg);
      logic [`LUT_ADDR_W-1:0] a;
      a = '0;
      addr_q.delete();
      for (int it = 0; it < int'(cfg.iterations); it++) begin
         for (int p = 0; p < int'(cfg.period); p++) begin
            if (p < int'(cfg.duty)) begin
               addr_q.push_back(a);
               a = a + cfg.incr;
            end
         end
         a = a + cfg.shift;
      end
   endtask

   function automatic lut_cfg_t pattern_cfg(input int iter, input int period, input int duty,
                                            input int incr, input int shift, input int beats,
                                            input logic pp, input logic [31:0] ext);
      lut_cfg_t cfg;
      int len;
      len = beats - 1;
      cfg = '0;
      cfg.ext_addr = ext;
      cfg.iterations = iter[`LUT_ADDR_W-1:0];
      cfg.period = period[`LUT_ADDR_W-1:0];
      cfg.duty = duty[`LUT_ADDR_W-1:0];
      cfg.incr = incr[`LUT_ADDR_W-1:0];
      cfg.shift = shift[`LUT_ADDR_W-1:0];
      cfg.length = len[`LUT_LEN_W-1:0];
      cfg.ping_pong = pp;
      return cfg;
   endfunction

   function automatic logic read_bank();
      return cfg_i.ping_pong ? !load_bank : 1'b0;
   endfunction

   function automatic logic [`LUT_DATA_W-1:0] expected_entry(input logic bank, input int idx);
      logic [`LUT_WORD_W-1:0] w;
      logic [`LUT_DATA_W-1:0] r;
      w = shadow[{bank, idx[`LUT_ADDR_W:1]}];
      r = '0;
      r[`LUT_LANE_W-1:0] = idx[0] ? w[2*`LUT_LANE_W-1:`LUT_LANE_W] : w[`LUT_LANE_W-1:0];
      return r;
   endfunction

   task automatic compare_data(input string name, input logic [`LUT_DATA_W-1:0] got,
                               input logic [`LUT_DATA_W-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic compare_done(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s got %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic compare_bus(input string name, input lut_bus_req_t got,
                              input lut_bus_req_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s got valid %b addr %h len %h, expected valid %b addr %h len %h",
                  $time, name, got.valid, got.addr, got.len, exp.valid, exp.addr, exp.len);
      end
   endtask

   task automatic start_run(input lut_cfg_t cfg, input logic skip);
      @(negedge clk);
      cfg_i = cfg;
      disabled_i = skip;
      load_bank = cfg.ping_pong ? !load_bank : 1'b0;
      if (!skip) begin
         queue_load_addresses(cfg);
      end
      run_i = 1'b1;
      @(negedge clk);
      run_i = 1'b0;
      disabled_i = 1'b0;
   endtask

   task automatic wait_done(input int limit);
      int n;
      n = 0;
      while (done_o !== 1'b1 && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (done_o !== 1'b1) begin
         $display("Timeout: done_o did not rise within %0d cycles", limit);
         errors++;
         aborted = 1'b1;
      end else begin
         // The bus model books the final beat on the falling edge after it
         @(posedge clk);
         if (addr_q.size() != 0) begin
            $display("Load ended with %0d generated addresses never written", addr_q.size());
            errors++;
         end
      end
   endtask

   // One index per cycle, each result checked two edges after its index
   task automatic read_stream(input logic bank);
      logic [`LUT_DATA_W-1:0] exp_q [$];
      int sent_q [$];
      int n;
      n = idx_list.size();
      for (int i = 0; i < n + 2; i++) begin
         @(negedge clk);
         if (i >= 2) begin
            compare_data($sformatf("data_o[index %0d]", sent_q.pop_front()), data_o,
                         exp_q.pop_front());
         end
         if (i < n) begin
            index_i = idx_list[i];
            sent_q.push_back(idx_list[i]);
            exp_q.push_back(expected_entry(bank, idx_list[i]));
         end
      end
   endtask

   task automatic sequential_indices(input int count);
      idx_list.delete();
      for (int i = 0; i < count; i++) begin
         idx_list.push_back(i);
      end
   endtask

   task automatic report_test(input string name, input int start);
      $display("Test %s finished with %0d errors", name, errors - start);
   endtask

   task automatic test_contiguous_load();
      lut_cfg_t cfg;
      lut_bus_req_t exp_req;
      int start;
      start = errors;
      cfg = pattern_cfg(1, 128, 128, 1, 0, 128, 1'b0, 32'h8000_1000);
      start_run(cfg, 1'b0);
      exp_req.valid = 1'b1;
      exp_req.addr = cfg.ext_addr;
      exp_req.len = cfg.length;
      compare_done("done_o", done_o, 1'b0);
      compare_bus("bus_req_o", bus_req_o, exp_req);
      wait_done(2000);
      sequential_indices(256);
      read_stream(read_bank());
      report_test("contiguous_load", start);
   endtask

   task automatic test_read_latency();
      int start;
      start = errors;
      idx_list.delete();
      // Scattered order so consecutive reads hit different words and lanes
      for (int i = 0; i < 100; i++) begin
         idx_list.push_back((i * 37 + 11) % 256);
      end
      read_stream(read_bank());
      report_test("read_latency", start);
   endtask

   task automatic test_address_pattern();
      int start;
      start = errors;
      start_run(pattern_cfg(4, 6, 3, 2, 5, 12, 1'b0, 32'h8000_4000), 1'b0);
      wait_done(2000);
      sequential_indices(256);
      read_stream(read_bank());
      report_test("address_pattern", start);
   endtask

   task automatic test_ping_pong();
      int start;
      start = errors;
      start_run(pattern_cfg(1, 64, 64, 1, 0, 64, 1'b1, 32'h8000_8000), 1'b0);
      wait_done(2000);
      if (!aborted) begin
         start_run(pattern_cfg(1, 64, 64, 1, 0, 64, 1'b1, 32'h8000_9000), 1'b0);
         sequential_indices(128);
         read_stream(read_bank());
         wait_done(2000);
         read_stream(read_bank());
      end
      report_test("ping_pong", start);
   endtask

   task automatic test_disabled_run();
      int start;
      start = errors;
      start_run(pattern_cfg(1, 16, 16, 1, 0, 16, 1'b0, 32'h8000_c000), 1'b1);
      for (int i = 0; i < 50; i++) begin
         compare_done("done_o", done_o, 1'b1);
         compare_done("bus_req_o.valid", bus_req_o.valid, 1'b0);
         @(negedge clk);
      end
      report_test("disabled_run", start);
   endtask

   task automatic test_backpressure();
      int start;
      start = errors;
      backpressure = 1'b1;
      start_run(pattern_cfg(1, 128, 128, 1, 0, 128, 1'b0, 32'h8000_d000), 1'b0);
      wait_done(5000);
      backpressure = 1'b0;
      sequential_indices(256);
      read_stream(read_bank());
      report_test("backpressure", start);
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      run_i = 1'b0;
      disabled_i = 1'b0;
      cfg_i = '0;
      index_i = '0;
      load_bank = 1'b0;
      backpressure = 1'b0;
      aborted = 1'b0;
      errors = 0;
      checks = 0;
      repeat (10) @(negedge clk);
      rst = 1'b0;
      if (!aborted) test_contiguous_load();
      if (!aborted) test_read_latency();
      if (!aborted) test_address_pattern();
      if (!aborted) test_ping_pong();
      if (!aborted) test_disabled_run();
      if (!aborted) test_backpressure();
      errors += lut_top_i.u_checks.valid_fails;
      errors += lut_top_i.u_checks.overlap_fails;
      errors += lut_top_i.u_checks.write_fails;
      $display("Tests finished: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
hdl/lut_pkg.sv
hdl/lut_addr_gen.sv
hdl/lut_mem_writer.sv
hdl/lut_table_ram.sv
hdl/lut_reader.sv
hdl/lut_top.sv
testbench/lut_tb_assertions.sv
testbench/lut_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lut_tb -Mdir obj_dir -f sources.f

status=0
./obj_dir/Vlut_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
if [ "$status" -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi
exit 0
